// ==== verilog/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	////////////////////
	// Basic widths
	////////////////////

	// Data word and address
	typedef logic [31:0] word;

	// General register number
	typedef logic [4:0] regIdx;

	// Primary opcode and R-type funct field
	typedef logic [5:0] opcode;

	////////////////////
	// Opcodes and functs
	////////////////////

	localparam opcode opRtype = 6'h00;
	localparam opcode opJ     = 6'h02;
	localparam opcode opJal   = 6'h03;
	localparam opcode opBeq   = 6'h04;
	localparam opcode opOri   = 6'h0d;
	localparam opcode opLui   = 6'h0f;
	localparam opcode opLw    = 6'h23;
	localparam opcode opSw    = 6'h2b;

	// Funct values under opRtype
	localparam opcode fnJr   = 6'h08;
	localparam opcode fnAddu = 6'h21;
	localparam opcode fnSubu = 6'h23;

	////////////////////
	// Control encodings
	////////////////////

	// Immediate extension, code 3 is left free
	typedef logic [1:0] extOp;
	localparam extOp extZero = 2'd0;
	localparam extOp extSign = 2'd1;
	localparam extOp extHigh = 2'd2;

	// Next-PC source
	typedef logic [1:0] npcOp;
	localparam npcOp npcSeq    = 2'd0;
	localparam npcOp npcBranch = 2'd1;
	localparam npcOp npcJump   = 2'd2;
	localparam npcOp npcReg    = 2'd3;

	////////////////////
	// Bundles
	////////////////////

	// Decoded control for one instruction
	typedef struct packed {
		logic  regWrite;
		logic  link;
		extOp  extSel;
		npcOp  npcSel;
		regIdx dst;
	} ctrl;

	// Write-back stage request to the register file
	typedef struct packed {
		word   instr;
		regIdx addr;
		word   data;
	} wbPort;

endpackage

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  mipsPkg::word instr,
	output mipsPkg::ctrl ctrl
);

	mipsPkg::opcode op;
	mipsPkg::opcode funct;
	mipsPkg::regIdx rt;
	mipsPkg::regIdx rd;

	// Instruction fields
	assign op    = instr[31:26];
	assign funct = instr[5:0];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];

	always_comb begin
		// No-op defaults, also used for unknown encodings
		ctrl.regWrite = 1'b0;
		ctrl.link     = 1'b0;
		ctrl.extSel   = mipsPkg::extZero;
		ctrl.npcSel   = mipsPkg::npcSeq;
		ctrl.dst      = '0;

		case (op)
			mipsPkg::opRtype: begin
				case (funct)
					mipsPkg::fnAddu,
					mipsPkg::fnSubu: begin
						ctrl.regWrite = 1'b1;
						ctrl.dst      = rd;
					end
					mipsPkg::fnJr: begin
						ctrl.npcSel = mipsPkg::npcReg;
					end
					default: begin
						// sll $0 and anything else stays a nop
						ctrl.regWrite = 1'b0;
					end
				endcase
			end

			mipsPkg::opOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.dst      = rt;
			end

			mipsPkg::opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.extSel   = mipsPkg::extSign;
				ctrl.dst      = rt;
			end

			// Store offset only, nothing written back
			mipsPkg::opSw: begin
				ctrl.extSel = mipsPkg::extSign;
			end

			mipsPkg::opBeq: begin
				ctrl.extSel = mipsPkg::extSign;
				ctrl.npcSel = mipsPkg::npcBranch;
			end

			mipsPkg::opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.extSel   = mipsPkg::extHigh;
				ctrl.dst      = rt;
			end

			mipsPkg::opJ: begin
				ctrl.npcSel = mipsPkg::npcJump;
			end

			// Link goes to $ra
			mipsPkg::opJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.link     = 1'b1;
				ctrl.npcSel   = mipsPkg::npcJump;
				ctrl.dst      = 5'd31;
			end

			default: begin
				ctrl.regWrite = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  wire          clk,
	input  wire          reset,
	input  mipsPkg::regIdx ra1,
	input  mipsPkg::regIdx ra2,
	input  mipsPkg::regIdx wa,
	input  wire          we,
	input  mipsPkg::word wd,
	output mipsPkg::word rd1,
	output mipsPkg::word rd2
);

	mipsPkg::word regs [32];
	logic         wrValid;

	// $0 is never stored
	assign wrValid = we && (wa != '0);

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrValid) begin
			regs[wa] <= wd;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// Same-cycle write wins over the stored word
	function automatic mipsPkg::word readPort(input mipsPkg::regIdx addr);
		mipsPkg::word val;
		if (addr == '0) begin
			val = '0;
		end else if (wrValid && (addr == wa)) begin
			val = wd;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		rd1 = readPort(ra1);
		rd2 = readPort(ra2);
	end

endmodule

`default_nettype wire

// ==== verilog/immExtend.sv ====
`timescale 1ns/1ps
`default_nettype none

module immExtend (
	input  logic [15:0]   imm16,
	input  mipsPkg::extOp extSel,
	output mipsPkg::word  imm
);

	always_comb begin
		case (extSel)
			mipsPkg::extZero: begin
				imm = {16'h0000, imm16};
			end
			mipsPkg::extSign: begin
				imm = {{16{imm16[15]}}, imm16};
			end
			// lui places the field on top
			mipsPkg::extHigh: begin
				imm = {imm16, 16'h0000};
			end
			default: begin
				// Free code, all ones flags a bad decode
				imm = 32'hffff_ffff;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/nextPc.sv ====
`timescale 1ns/1ps
`default_nettype none

module nextPc (
	input  mipsPkg::word  pc4,
	input  mipsPkg::word  instr,
	input  mipsPkg::npcOp npcSel,
	input  mipsPkg::word  rs,
	input  mipsPkg::word  rt,
	output mipsPkg::word  npc,
	output logic          branchTaken
);

	logic         equal;
	mipsPkg::word pc;
	mipsPkg::word brOffset;
	mipsPkg::word jumpTarget;

	////////////////////
	// Branch compare
	////////////////////

	assign equal = (rs == rt);

	assign branchTaken = (npcSel == mipsPkg::npcBranch) && equal;

	////////////////////
	// Targets
	////////////////////

	// Address of the instruction itself
	assign pc = pc4 - 32'd4;

	// Word offset, sign extended and shifted by two
	assign brOffset = {{14{instr[15]}}, instr[15:0], 2'b00};

	// Region bits come from the jump's own address
	assign jumpTarget = {pc[31:28], instr[25:0], 2'b00};

	always_comb begin
		case (npcSel)
			mipsPkg::npcBranch: begin
				if (equal) begin
					npc = pc4 + brOffset;
				end else begin
					npc = pc4 + 32'd4;
				end
			end
			mipsPkg::npcJump: begin
				npc = jumpTarget;
			end
			mipsPkg::npcReg: begin
				npc = rs;
			end
			default: begin
				npc = pc4;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  wire           clk,
	input  wire           reset,
	input  mipsPkg::word  instr,
	input  mipsPkg::word  pc4,
	input  mipsPkg::wbPort wb,
	output mipsPkg::ctrl  ctrl,
	output mipsPkg::word  rd1,
	output mipsPkg::word  rd2,
	output mipsPkg::word  imm,
	output mipsPkg::word  npc,
	output logic          branchTaken
);

	mipsPkg::ctrl ctrlD;
	mipsPkg::ctrl ctrlW;

	////////////////////
	// Decoders
	////////////////////

	// Instruction now in decode
	instrDecoder decodeD (
		.instr (instr),
		.ctrl  (ctrlD)
	);

	// Instruction in write-back, only its write enable is needed
	instrDecoder decodeW (
		.instr (wb.instr),
		.ctrl  (ctrlW)
	);

	assign ctrl = ctrlD;

	////////////////////
	// Register file
	////////////////////

	// Destination and data arrive from write-back
	regFile u_regFile (
		.clk   (clk),
		.reset (reset),
		.ra1   (instr[25:21]),
		.ra2   (instr[20:16]),
		.wa    (wb.addr),
		.we    (ctrlW.regWrite),
		.wd    (wb.data),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	////////////////////
	// Immediate and next PC
	////////////////////

	immExtend u_immExtend (
		.imm16  (instr[15:0]),
		.extSel (ctrlD.extSel),
		.imm    (imm)
	);

	// Compare uses the register values read above
	nextPc u_nextPc (
		.pc4         (pc4),
		.instr       (instr),
		.npcSel      (ctrlD.npcSel),
		.rs          (rd1),
		.rt          (rd2),
		.npc         (npc),
		.branchTaken (branchTaken)
	);

endmodule

`default_nettype wire

// ==== verif/decodeStage_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage_sva (
	input  wire            clk,
	input  wire            reset,
	input  mipsPkg::word   instr,
	input  mipsPkg::word   pc4,
	input  mipsPkg::wbPort wb,
	input  mipsPkg::ctrl   ctrl,
	input  mipsPkg::word   rd1,
	input  mipsPkg::word   rd2,
	input  mipsPkg::word   imm,
	input  mipsPkg::word   npc,
	input  wire            branchTaken
);

	int             failCount = 0;
	mipsPkg::word   shadow [32];
	mipsPkg::opcode op;
	mipsPkg::opcode wbOp;
	mipsPkg::regIdx rs;
	mipsPkg::regIdx rt;
	mipsPkg::word   pcSelf;
	mipsPkg::word   expRd1;
	mipsPkg::word   expRd2;
	mipsPkg::word   expImm;
	mipsPkg::word   expNpc;
	mipsPkg::regIdx expDst;
	logic           expWrite;
	logic           expTaken;
	logic           wbWrite;
	logic           knownOp;

	assign op     = instr[31:26];
	assign wbOp   = wb.instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign pcSelf = pc4 - 32'd4;

	////////////////////
	// Shadow registers
	////////////////////

	// Write-back instructions that produce a result: addu, subu, ori, lw, lui, jal
	always_comb begin
		case (wbOp)
			mipsPkg::opRtype: begin
				wbWrite = (wb.instr[5:0] == mipsPkg::fnAddu) || (wb.instr[5:0] == mipsPkg::fnSubu);
			end
			mipsPkg::opOri, mipsPkg::opLw, mipsPkg::opLui, mipsPkg::opJal: begin
				wbWrite = 1'b1;
			end
			default: begin
				wbWrite = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				shadow[i] <= '0;
			end
		end else if (wbWrite && (wb.addr != '0)) begin
			shadow[wb.addr] <= wb.data;
		end
	end

	////////////////////
	// Expected outputs
	////////////////////

	always_comb begin
		// Stored value, then same-cycle write, then $0
		expRd1 = shadow[rs];
		if (wbWrite && (wb.addr == rs)) begin
			expRd1 = wb.data;
		end
		if (rs == '0) begin
			expRd1 = '0;
		end
		expRd2 = shadow[rt];
		if (wbWrite && (wb.addr == rt)) begin
			expRd2 = wb.data;
		end
		if (rt == '0) begin
			expRd2 = '0;
		end

		case (op)
			mipsPkg::opLw, mipsPkg::opSw, mipsPkg::opBeq: expImm = {{16{instr[15]}}, instr[15:0]};
			mipsPkg::opLui: expImm = {instr[15:0], 16'h0000};
			default: expImm = {16'h0000, instr[15:0]};
		endcase

		// Destination rd for R-type, rt for I-type, $ra for jal
		expWrite = 1'b0;
		expDst   = rt;
		case (op)
			mipsPkg::opRtype: begin
				expWrite = (instr[5:0] == mipsPkg::fnAddu) || (instr[5:0] == mipsPkg::fnSubu);
				expDst   = instr[15:11];
			end
			mipsPkg::opOri, mipsPkg::opLw, mipsPkg::opLui: expWrite = 1'b1;
			mipsPkg::opJal: begin
				expWrite = 1'b1;
				expDst   = 5'd31;
			end
			default: expWrite = 1'b0;
		endcase

		expTaken = (op == mipsPkg::opBeq) && (expRd1 == expRd2);
		knownOp  = 1'b1;
		case (op)
			mipsPkg::opBeq: expNpc = expTaken ? pc4 + {{14{instr[15]}}, instr[15:0], 2'b00}
				: pc4 + 32'd4;
			mipsPkg::opJ, mipsPkg::opJal: expNpc = {pcSelf[31:28], instr[25:0], 2'b00};
			mipsPkg::opRtype: expNpc = (instr[5:0] == mipsPkg::fnJr) ? expRd1 : pc4;
			mipsPkg::opOri, mipsPkg::opLw, mipsPkg::opSw, mipsPkg::opLui: expNpc = pc4;
			default: begin
				expNpc  = pc4;
				knownOp = 1'b0;
			end
		endcase
	end

	////////////////////
	// Assertions
	////////////////////

	rd1Check: assert property (@(posedge clk) disable iff (reset) rd1 == expRd1)
		else begin
			failCount++;
			$error("Fail rd1: got %h, expected %h", $sampled(rd1), $sampled(expRd1));
		end

	rd2Check: assert property (@(posedge clk) disable iff (reset) rd2 == expRd2)
		else begin
			failCount++;
			$error("Fail rd2: got %h, expected %h", $sampled(rd2), $sampled(expRd2));
		end

	immCheck: assert property (@(posedge clk) disable iff (reset) imm == expImm)
		else begin
			failCount++;
			$error("Fail imm: got %h, expected %h", $sampled(imm), $sampled(expImm));
		end

	npcCheck: assert property (@(posedge clk) disable iff (reset) npc == expNpc)
		else begin
			failCount++;
			$error("Fail npc: got %h, expected %h", $sampled(npc), $sampled(expNpc));
		end

	takenCheck: assert property (@(posedge clk) disable iff (reset) branchTaken == expTaken)
		else begin
			failCount++;
			$error("Fail branchTaken: got %h, expected %h", $sampled(branchTaken),
				$sampled(expTaken));
		end

	// Write enable, link flag and destination of the decoded control
	ctrlCheck: assert property (@(posedge clk) disable iff (reset)
		(ctrl.regWrite == expWrite) && (ctrl.link == (op == mipsPkg::opJal))
		&& (!expWrite || (ctrl.dst == expDst)))
		else begin
			failCount++;
			$error("Fail ctrl: got regWrite %h dst %h, expected regWrite %h dst %h",
				$sampled(ctrl.regWrite), $sampled(ctrl.dst), $sampled(expWrite),
				$sampled(expDst));
		end

	// jal links to $ra
	linkCheck: assert property (@(posedge clk) disable iff (reset)
		(op == mipsPkg::opJal) |-> (ctrl.regWrite && ctrl.link && (ctrl.dst == 5'd31)))
		else begin
			failCount++;
			$error("jal control does not link to register 31");
		end

	// Unknown opcodes behave as a nop
	nopCheck: assert property (@(posedge clk) disable iff (reset)
		!knownOp |-> (!ctrl.regWrite && (ctrl.npcSel == mipsPkg::npcSeq)))
		else begin
			failCount++;
			$error("unknown opcode did not decode as a nop");
		end

endmodule

bind decodeStage decodeStage_sva u_sva (
	.clk         (clk),
	.reset       (reset),
	.instr       (instr),
	.pc4         (pc4),
	.wb          (wb),
	.ctrl        (ctrl),
	.rd1         (rd1),
	.rd2         (rd2),
	.imm         (imm),
	.npc         (npc),
	.branchTaken (branchTaken)
);

`default_nettype wire

// ==== verif/decodeStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;

	logic           clk = 1'b0;
	logic           reset;
	mipsPkg::word   instr;
	mipsPkg::word   pc4;
	mipsPkg::wbPort wb;
	mipsPkg::ctrl   ctrl;
	mipsPkg::word   rd1;
	mipsPkg::word   rd2;
	mipsPkg::word   imm;
	mipsPkg::word   npc;
	logic           branchTaken;

	integer       seed;
	mipsPkg::word model [32];
	int           localErrs;
	int           assertBase;
	int           testsPassed;
	int           testsFailed;

	decodeStage u_dut (
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.pc4         (pc4),
		.wb          (wb),
		.ctrl        (ctrl),
		.rd1         (rd1),
		.rd2         (rd2),
		.imm         (imm),
		.npc         (npc),
		.branchTaken (branchTaken)
	);

	// 100 ns period
	always #50 clk = ~clk;

	////////////////////
	// Helpers
	////////////////////

	function automatic mipsPkg::word encodeR(input mipsPkg::regIdx rs, input mipsPkg::regIdx rt,
			input mipsPkg::regIdx rd, input mipsPkg::opcode funct);
		return {mipsPkg::opRtype, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic mipsPkg::word encodeI(input mipsPkg::opcode op, input mipsPkg::regIdx rs,
			input mipsPkg::regIdx rt, input logic [15:0] imm16);
		return {op, rs, rt, imm16};
	endfunction

	function automatic mipsPkg::word encodeJ(input mipsPkg::opcode op, input logic [25:0] index);
		return {op, index};
	endfunction

	task automatic waitFalling();
		int spins;
		spins = 0;
		while ((clk !== 1'b1) && (spins < 200)) begin
			#1;
			spins++;
		end
		while ((clk !== 1'b0) && (spins < 200)) begin
			#1;
			spins++;
		end
		if (spins >= 200) begin
			$display("Timed out waiting for a falling clock edge");
			$display("TEST FAIL");
			$finish;
		end
	endtask

	// New inputs just after the falling edge, outputs settle before the next rise
	task automatic drive(input mipsPkg::word nextInstr, input mipsPkg::word nextPc4,
			input mipsPkg::word wbInstr, input mipsPkg::regIdx wbAddr, input mipsPkg::word wbData);
		waitFalling();
		instr    = nextInstr;
		pc4      = nextPc4;
		wb.instr = wbInstr;
		wb.addr  = wbAddr;
		wb.data  = wbData;
		#10;
	endtask

	task automatic issue(input mipsPkg::word nextInstr, input mipsPkg::word nextPc4);
		drive(nextInstr, nextPc4, '0, '0, '0);
	endtask

	// addu write-back into one register
	task automatic writeReg(input mipsPkg::regIdx addr, input mipsPkg::word data);
		drive('0, 32'h0000_1004, encodeR(5'd0, 5'd0, addr, mipsPkg::fnAddu), addr, data);
		if (addr != '0) begin
			model[addr] = data;
		end
	endtask

	task automatic checkValue(input string name, input mipsPkg::word got, input mipsPkg::word exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			localErrs++;
		end
	endtask

	task automatic readBack(input mipsPkg::regIdx r);
		issue(encodeR(r, r, 5'd0, mipsPkg::fnAddu), 32'h0000_1004);
		checkValue("rd1", rd1, model[r]);
		checkValue("rd2", rd2, model[r]);
	endtask

	task automatic startTest();
		localErrs  = 0;
		assertBase = u_dut.u_sva.failCount;
	endtask

	task automatic finishTest(input string name);
		int errs;
		// Rising edge that samples the last inputs runs its assertions first
		waitFalling();
		errs = localErrs + (u_dut.u_sva.failCount - assertBase);
		if (errs == 0) begin
			$display("%s: passed", name);
			testsPassed++;
		end else begin
			$display("%s: failed with %0d errors", name, errs);
			testsFailed++;
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	initial begin
		int             r;
		mipsPkg::regIdx dst;
		mipsPkg::word   data;
		mipsPkg::word   pcVal;
		logic [15:0]    offset;
		seed        = 32'he2ea473a;
		reset       = 1'b1;
		instr       = '0;
		pc4         = '0;
		wb          = '0;
		testsPassed = 0;
		testsFailed = 0;
		for (r = 0; r < 32; r++) begin
			model[r] = '0;
		end
		repeat (3) waitFalling();
		reset = 1'b0;

		startTest();
		for (r = 0; r < 32; r++) begin
			readBack(r[4:0]);
		end
		for (r = 1; r < 32; r++) begin
			writeReg(r[4:0], $random(seed));
		end
		writeReg(5'd0, $random(seed));
		for (r = 0; r < 32; r++) begin
			readBack(r[4:0]);
		end
		finishTest("Register write and read");

		// Read and write of one register in the same cycle
		startTest();
		for (r = 0; r < 8; r++) begin
			dst  = 5'd1 + 5'($unsigned($random(seed)) % 31);
			data = $random(seed);
			if (r[0]) begin
				drive(encodeR(5'd0, dst, 5'd0, mipsPkg::fnAddu), 32'h0000_1004,
					encodeR(5'd0, 5'd0, dst, mipsPkg::fnAddu), dst, data);
				checkValue("rd2", rd2, data);
			end else begin
				drive(encodeR(dst, 5'd0, 5'd0, mipsPkg::fnAddu), 32'h0000_1004,
					encodeR(5'd0, 5'd0, dst, mipsPkg::fnAddu), dst, data);
				checkValue("rd1", rd1, data);
			end
			model[dst] = data;
		end
		finishTest("Write forwarding");

		startTest();
		for (r = 0; r < 12; r++) begin
			offset = (r == 0) ? 16'h8000 : 16'($random(seed));
			issue(encodeI(mipsPkg::opOri, 5'd1, 5'd2, offset), 32'h0000_2004);
			issue(encodeI(mipsPkg::opLw, 5'd3, 5'd4, offset), 32'h0000_2008);
			issue(encodeI(mipsPkg::opSw, 5'd5, 5'd6, offset), 32'h0000_200c);
			issue(encodeI(mipsPkg::opLui, 5'd0, 5'd7, offset), 32'h0000_2010);
		end
		finishTest("Immediate extension");

		// Registers 5 and 6 equal, 7 different
		startTest();
		data = $random(seed);
		writeReg(5'd5, data);
		writeReg(5'd6, data);
		writeReg(5'd7, ~data);
		for (r = 0; r < 8; r++) begin
			offset     = $random(seed);
			offset[15] = r[0];
			pcVal      = $random(seed);
			pcVal[1:0] = 2'b00;
			issue(encodeI(mipsPkg::opBeq, 5'd5, 5'd6, offset), pcVal);
			checkValue("branchTaken", branchTaken, 32'd1);
			issue(encodeI(mipsPkg::opBeq, 5'd5, 5'd7, offset), pcVal);
			checkValue("branchTaken", branchTaken, 32'd0);
		end
		finishTest("Branch compare");

		startTest();
		for (r = 0; r < 6; r++) begin
			pcVal      = $random(seed);
			pcVal[1:0] = 2'b00;
			issue(encodeJ(mipsPkg::opJ, 26'($random(seed))), pcVal);
			issue(encodeJ(mipsPkg::opJal, 26'($random(seed))), pcVal);
			checkValue("ctrl.dst", 32'(ctrl.dst), 32'd31);
			checkValue("ctrl.regWrite", 32'(ctrl.regWrite), 32'd1);
			dst = 5'd1 + 5'($unsigned($random(seed)) % 31);
			issue(encodeR(dst, 5'd0, 5'd0, mipsPkg::fnJr), pcVal);
			checkValue("npc", npc, model[dst]);
		end
		finishTest("Jumps");

		// Second reset, then an opcode outside the set
		startTest();
		waitFalling();
		reset = 1'b1;
		repeat (3) waitFalling();
		reset = 1'b0;
		for (r = 0; r < 32; r++) begin
			model[r] = '0;
		end
		for (r = 0; r < 32; r++) begin
			readBack(r[4:0]);
		end
		pcVal = 32'h0040_0100;
		issue(encodeJ(6'h3f, 26'($random(seed))), pcVal);
		checkValue("ctrl.regWrite", 32'(ctrl.regWrite), 32'd0);
		checkValue("npc", npc, pcVal);
		finishTest("Reset and unknown opcode");

		$display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (testsFailed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== decodeStage.f ====
verilog/mipsPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/immExtend.sv
verilog/nextPc.sv
verilog/decodeStage.sv
verif/decodeStage_sva.sv
verif/decodeStageTb.sv
